// ==== filelist.f ====
verilog/cam_mon_pkg.sv
verilog/mon_ctrl_if.sv
verilog/reg_bank.sv
verilog/pixel_repack.sv
verilog/window_timer.sv
verilog/monitor_fsm.sv
verilog/beat_counters.sv
verilog/cam_monitor_top.sv
test/cam_monitor_properties.sv
test/tb_cam_monitor.sv

// ==== Makefile ====
# Verilator build and run of the camera monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_cam_monitor
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# Build, run, then fail if the log reports failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Some tests failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_cam_monitor.sv ====
// Single clock; camera data and video stalls share one LFSR, frames must be shorter than a window
`timescale 1ns/1ns

module tb_cam_monitor import cam_mon_pkg::*;
();

   // ********************
   // Tables
   // ********************
   typedef struct packed
   {
      int lines;
      int pixels;
      bit stall;
   } frame_row_t;

   typedef struct packed
   {
      reg_addr_t        addr;
      reg_be_t          be;
      reg_data_t        data;
      reg_data_t        exp_rd;
      logic [LED_W-1:0] exp_led;
   } write_row_t;

   localparam int N_FRAMES = 4;
   localparam int N_WRITES = 5;
   // Lines, pixels per line, back-pressure
   localparam frame_row_t FRAMES [N_FRAMES] = '{
      '{3, 16, 1'b0},
      '{8, 24, 1'b1},
      '{5, 40, 1'b0},
      '{10, 30, 1'b1}
   };
   // Partial byte writes, then a write to the read-only version
   localparam write_row_t WRITES [N_WRITES] = '{
      '{REG_LED_CTRL, 4'b0001, 32'hA5A5_A5A5, 32'h0000_00A5, 4'h5},
      '{REG_LED_CTRL, 4'b0100, 32'h1234_5678, 32'h0034_00A5, 4'h5},
      '{REG_LED_CTRL, 4'b1010, 32'hFFFF_FFFF, 32'hFF34_FFA5, 4'h5},
      '{REG_LED_CTRL, 4'b0001, 32'h0000_000C, 32'hFF34_FF0C, 4'hC},
      '{REG_FW_VER,   4'b1111, 32'hFFFF_FFFF, FW_VERSION,    4'hC}
   };

   localparam int BEAT_TIMEOUT  = 100;
   localparam int DRAIN_TIMEOUT = 200;
   localparam int POLL_TIMEOUT  = 3000;

   // ********************
   // DUT signals
   // ********************
   logic             reg_ctrl_clk;
   logic             arst_n_i;
   logic             reg_en_i;
   reg_be_t          reg_we_i;
   reg_addr_t        reg_addr_i;
   reg_data_t        reg_wdata_i;
   reg_data_t        reg_rdata_o;
   pix565_t          cam_tdata_i;
   logic             cam_tvalid_i;
   logic             cam_tuser_i;
   logic             cam_tlast_i;
   logic             cam_tready_o;
   pix888_t          vid_tdata_o;
   logic             vid_tvalid_o;
   logic             vid_tuser_o;
   logic             vid_tlast_o;
   logic             vid_tready_i;
   logic [LED_W-1:0] led_o;

   // Testbench state
   logic [31:0] lfsr_q = 32'hff59;
   logic [31:0] exp_q [$];
   logic        stall_en = 1'b0;
   logic        cam_accepted = 1'b0;
   int          checks = 0;
   int          value_errs = 0;
   int          other_errs = 0;

   cam_monitor_top u_cam_monitor_top (.*);

   bind cam_monitor_top cam_monitor_properties u_cam_monitor_properties
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .arst_n_i     ( arst_n_i ),
      .vid_tdata_o  ( vid_tdata_o ),
      .vid_tvalid_o ( vid_tvalid_o ),
      .vid_tuser_o  ( vid_tuser_o ),
      .vid_tlast_o  ( vid_tlast_o ),
      .vid_tready_i ( vid_tready_i ),
      .cam_tready_o ( cam_tready_o )
   );

   initial
   begin
      reg_ctrl_clk = 1'b0;
      forever #5 reg_ctrl_clk = ~reg_ctrl_clk;
   end

   // ********************
   // Helpers
   // ********************
   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit
   task automatic take_bits(input int n, output logic [15:0] bits);
      int i;
      bits = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         bits   = {bits[14:0], lfsr_q[0]};
      end
   endtask

   // Channels moved to the top of their bytes, zeros below
   function automatic pix888_t expand_pixel(input pix565_t p);
      pix888_t v;
      v        = '0;
      v[23:19] = p[4:0];
      v[15:11] = p[15:11];
      v[7:2]   = p[10:5];
      return v;
   endfunction

   // Window count in 15..8, state in 1..0
   function automatic reg_data_t make_status(input logic [7:0] wins, input mon_state_t st);
      return (32'(wins) << 8) | 32'(st);
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act)
      begin
         value_errs++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic finish_run();
      $display("Checks: %0d, value errors: %0d, other errors: %0d",
               checks, value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
      begin
         $display("All tests passed");
      end
      else
      begin
         $display("Some tests failed");
      end
      $finish;
   endtask

   // Edge, then scoreboard on pre-edge values, then next ready
   task automatic next_cycle();
      logic [15:0] rnd;
      @(posedge reg_ctrl_clk);
      cam_accepted = cam_tvalid_i && cam_tready_o;
      if (vid_tvalid_o && vid_tready_i)
      begin
         if (exp_q.size() == 0)
         begin
            other_errs++;
            $display("Video beat came out with nothing expected");
         end
         else
         begin
            check("repack", exp_q.pop_front(), {6'd0, vid_tuser_o, vid_tlast_o, vid_tdata_o});
         end
      end
      if (stall_en)
      begin
         take_bits(1, rnd);
         vid_tready_i <= rnd[0];
      end
      else
      begin
         vid_tready_i <= 1'b1;
      end
   endtask

   // ********************
   // Register access
   // ********************
   task automatic write_reg(input reg_addr_t addr, input reg_be_t be, input reg_data_t data);
      reg_en_i    <= 1'b1;
      reg_we_i    <= be;
      reg_addr_i  <= addr;
      reg_wdata_i <= data;
      next_cycle();
      reg_en_i    <= 1'b0;
      reg_we_i    <= '0;
   endtask

   // Data is captured at the first edge and sampled at the second
   task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
      reg_en_i   <= 1'b1;
      reg_we_i   <= '0;
      reg_addr_i <= addr;
      next_cycle();
      reg_en_i   <= 1'b0;
      next_cycle();
      data = reg_rdata_o;
   endtask

   task automatic check_reg(input string name, input reg_addr_t addr, input reg_data_t exp);
      reg_data_t rd;
      read_reg(addr, rd);
      check(name, exp, rd);
   endtask

   // Poll the status word until it matches
   task automatic wait_for_state(input mon_state_t st, input logic [7:0] wins);
      reg_data_t rd;
      int        polls;
      polls = 0;
      read_reg(REG_STATUS, rd);
      while (rd !== make_status(wins, st))
      begin
         polls++;
         if (polls > POLL_TIMEOUT)
         begin
            other_errs++;
            $display("Timed out waiting for monitor state %0d after %0d windows", st, wins);
            finish_run();
         end
         read_reg(REG_STATUS, rd);
      end
   endtask

   // ********************
   // Stream driver
   // ********************
   task automatic send_frame(input int lines, input int pixels);
      logic [15:0] pix;
      logic        user;
      logic        last;
      int          ln;
      int          px;
      int          waited;
      for (ln = 0; ln < lines; ln++)
      begin
         for (px = 0; px < pixels; px++)
         begin
            take_bits(16, pix);
            user = (ln == 0) && (px == 0);
            last = (px == pixels - 1);
            cam_tdata_i  <= pix;
            cam_tvalid_i <= 1'b1;
            cam_tuser_i  <= user;
            cam_tlast_i  <= last;
            exp_q.push_back({6'd0, user, last, expand_pixel(pix)});
            waited = 0;
            cam_accepted = 1'b0;
            while (!cam_accepted)
            begin
               next_cycle();
               waited++;
               if (waited > BEAT_TIMEOUT)
               begin
                  other_errs++;
                  $display("Timed out waiting for camera beat %0d of line %0d", px, ln);
                  finish_run();
               end
            end
         end
      end
      cam_tvalid_i <= 1'b0;
   endtask

   // Wait until every expected video beat has left
   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0)
      begin
         next_cycle();
         waited++;
         if (waited > DRAIN_TIMEOUT)
         begin
            other_errs++;
            $display("Timed out with %0d video beats still missing", exp_q.size());
            finish_run();
         end
      end
   endtask

   // ********************
   // Main sequence
   // ********************
   initial
   begin
      int          r;
      reg_data_t   exp_stats;
      reg_data_t   rd;
      logic [7:0]  exp_windows;
      arst_n_i     = 1'b0;
      reg_en_i     = 1'b0;
      reg_we_i     = '0;
      reg_addr_i   = '0;
      reg_wdata_i  = '0;
      cam_tdata_i  = '0;
      cam_tvalid_i = 1'b0;
      cam_tuser_i  = 1'b0;
      cam_tlast_i  = 1'b0;
      vid_tready_i = 1'b1;
      exp_windows  = '0;
      exp_stats    = '0;
      repeat (10) @(posedge reg_ctrl_clk);
      arst_n_i <= 1'b1;
      next_cycle();

      // Reset values
      check_reg("fw version", REG_FW_VER, FW_VERSION);
      check_reg("led ctrl reset", REG_LED_CTRL, 32'd0);
      check_reg("mon ctrl reset", REG_MON_CTRL, 32'd0);
      check_reg("in stats reset", REG_IN_STATS, 32'd0);
      check_reg("out stats reset", REG_OUT_STATS, 32'd0);
      check_reg("status reset", REG_STATUS, make_status(8'd0, MON_IDLE));
      check("led reset", 32'd0, 32'(led_o));
      check("cam ready reset", 32'd1, 32'(cam_tready_o));

      // Byte-enabled writes
      for (r = 0; r < N_WRITES; r++)
      begin
         write_reg(WRITES[r].addr, WRITES[r].be, WRITES[r].data);
         read_reg(WRITES[r].addr, rd);
         check("write readback", WRITES[r].exp_rd, rd);
         check("led value", 32'(WRITES[r].exp_led), 32'(led_o));
      end

      // One frame per window
      write_reg(REG_MON_CTRL, 4'b0001, 32'h0000_0001);
      for (r = 0; r < N_FRAMES; r++)
      begin
         stall_en = FRAMES[r].stall;
         wait_for_state(MON_ARM, exp_windows);
         send_frame(FRAMES[r].lines, FRAMES[r].pixels);
         drain();
         // Window still open, stats keep the previous snapshot
         check_reg("in stats before latch", REG_IN_STATS, exp_stats);
         check_reg("out stats before latch", REG_OUT_STATS, exp_stats);
         exp_windows = exp_windows + 1'b1;
         wait_for_state(MON_ARM, exp_windows);
         exp_stats = (32'd1 << 24) | (32'(FRAMES[r].lines) << 12)
                   | 32'(FRAMES[r].lines * FRAMES[r].pixels);
         check_reg("in stats", REG_IN_STATS, exp_stats);
         check_reg("out stats", REG_OUT_STATS, exp_stats);
      end

      // Disabled monitor keeps its last results
      write_reg(REG_MON_CTRL, 4'b0001, 32'h0000_0000);
      wait_for_state(MON_IDLE, exp_windows);
      stall_en = 1'b1;
      send_frame(4, 20);
      drain();
      check_reg("in stats held", REG_IN_STATS, exp_stats);
      check_reg("out stats held", REG_OUT_STATS, exp_stats);
      check_reg("status held", REG_STATUS, make_status(exp_windows, MON_IDLE));

      finish_run();
   end

endmodule

// ==== test/cam_monitor_properties.sv ====
// Checks the video-side handshake only; sampled on reg_ctrl_clk, most checks idle during reset
`timescale 1ns/1ns

module cam_monitor_properties import cam_mon_pkg::*;
(
   input  logic    reg_ctrl_clk,
   input  logic    arst_n_i,
   input  pix888_t vid_tdata_o,
   input  logic    vid_tvalid_o,
   input  logic    vid_tuser_o,
   input  logic    vid_tlast_o,
   input  logic    vid_tready_i,
   input  logic    cam_tready_o
);

   // ********************
   // Video handshake
   // ********************
   // Stalled beat must hold until taken
   property p_hold_when_stalled;
      @(posedge reg_ctrl_clk) disable iff (!arst_n_i)
      (vid_tvalid_o && !vid_tready_i) |=>
         (vid_tvalid_o && $stable(vid_tdata_o) && $stable(vid_tuser_o) && $stable(vid_tlast_o));
   endproperty

   // Stage comes out of reset empty
   property p_empty_after_reset;
      @(posedge reg_ctrl_clk) $rose(arst_n_i) |-> !vid_tvalid_o;
   endproperty

   // A draining stage always has room
   property p_ready_passes_through;
      @(posedge reg_ctrl_clk) disable iff (!arst_n_i)
      vid_tready_i |-> cam_tready_o;
   endproperty

   a_hold_when_stalled: assert property (p_hold_when_stalled)
      else $error("video beat changed while stalled");
   a_empty_after_reset: assert property (p_empty_after_reset)
      else $error("vid_tvalid_o high in the first cycle after reset");
   a_ready_passes_through: assert property (p_ready_passes_through)
      else $error("cam_tready_o low while vid_tready_i high");

endmodule

// ==== verilog/cam_monitor_top.sv ====
// One clock, asynchronous active-low reset; camera and video streams share reg_ctrl_clk
`timescale 1ns/1ns

module cam_monitor_top import cam_mon_pkg::*;
(
   input  logic             reg_ctrl_clk,
   input  logic             arst_n_i,
   // Register port
   input  logic             reg_en_i,
   input  reg_be_t          reg_we_i,
   input  reg_addr_t        reg_addr_i,
   input  reg_data_t        reg_wdata_i,
   output reg_data_t        reg_rdata_o,
   // Camera stream
   input  pix565_t          cam_tdata_i,
   input  logic             cam_tvalid_i,
   input  logic             cam_tuser_i,
   input  logic             cam_tlast_i,
   output logic             cam_tready_o,
   // Video stream
   output pix888_t          vid_tdata_o,
   output logic             vid_tvalid_o,
   output logic             vid_tuser_o,
   output logic             vid_tlast_o,
   input  logic             vid_tready_i,
   // Board LEDs
   output logic [LED_W-1:0] led_o
);

   // ********************
   // Wires
   // ********************
   reg_data_t in_stats;
   reg_data_t out_stats;
   logic      mon_enable;
   logic      win_tick;
   logic      win_start;
   logic      sof_beat;

   mon_ctrl_if u_mon_ctrl ();

   // Accepted camera frame start
   assign sof_beat = cam_tvalid_i && cam_tready_o && cam_tuser_i;

   reg_bank u_reg_bank
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .arst_n_i     ( arst_n_i ),
      .reg_en_i     ( reg_en_i ),
      .reg_we_i     ( reg_we_i ),
      .reg_addr_i   ( reg_addr_i ),
      .reg_wdata_i  ( reg_wdata_i ),
      .reg_rdata_o  ( reg_rdata_o ),
      .in_stats_i   ( in_stats ),
      .out_stats_i  ( out_stats ),
      .mon_enable_o ( mon_enable ),
      .led_o        ( led_o ),
      .ctrl         ( u_mon_ctrl )
   );

   pixel_repack u_pixel_repack
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .arst_n_i     ( arst_n_i ),
      .cam_tdata_i  ( cam_tdata_i ),
      .cam_tvalid_i ( cam_tvalid_i ),
      .cam_tuser_i  ( cam_tuser_i ),
      .cam_tlast_i  ( cam_tlast_i ),
      .cam_tready_o ( cam_tready_o ),
      .vid_tdata_o  ( vid_tdata_o ),
      .vid_tvalid_o ( vid_tvalid_o ),
      .vid_tuser_o  ( vid_tuser_o ),
      .vid_tlast_o  ( vid_tlast_o ),
      .vid_tready_i ( vid_tready_i )
   );

   // ********************
   // Measurement control
   // ********************
   window_timer u_window_timer
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .arst_n_i     ( arst_n_i ),
      .start_i      ( win_start ),
      .tick_o       ( win_tick )
   );

   monitor_fsm u_monitor_fsm
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .arst_n_i     ( arst_n_i ),
      .enable_i     ( mon_enable ),
      .sof_beat_i   ( sof_beat ),
      .tick_i       ( win_tick ),
      .start_o      ( win_start ),
      .ctrl         ( u_mon_ctrl )
   );

   // Camera side counts
   beat_counters u_in_counters
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .arst_n_i     ( arst_n_i ),
      .valid_i      ( cam_tvalid_i ),
      .ready_i      ( cam_tready_o ),
      .tuser_i      ( cam_tuser_i ),
      .tlast_i      ( cam_tlast_i ),
      .ctrl         ( u_mon_ctrl ),
      .stats_o      ( in_stats )
   );

   // Video side counts
   beat_counters u_out_counters
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .arst_n_i     ( arst_n_i ),
      .valid_i      ( vid_tvalid_o ),
      .ready_i      ( vid_tready_i ),
      .tuser_i      ( vid_tuser_o ),
      .tlast_i      ( vid_tlast_o ),
      .ctrl         ( u_mon_ctrl ),
      .stats_o      ( out_stats )
   );

endmodule

// ==== verilog/beat_counters.sv ====
// Counts only while count_en is high; each field saturates and a clear in the same cycle still counts
`timescale 1ns/1ns

module beat_counters import cam_mon_pkg::*;
(
   input  logic        reg_ctrl_clk,
   input  logic        arst_n_i,
   // Observed stream
   input  logic        valid_i,
   input  logic        ready_i,
   input  logic        tuser_i,
   input  logic        tlast_i,
   mon_ctrl_if.counter ctrl,
   // Frame starts, line ends, beats
   output reg_data_t   stats_o
);

   sof_cnt_t  sof_q;
   eol_cnt_t  eol_q;
   beat_cnt_t beat_q;
   sof_cnt_t  sof_nxt;
   eol_cnt_t  eol_nxt;
   beat_cnt_t beat_nxt;
   logic      hit;

   // Beat transfers this cycle inside the window
   assign hit = ctrl.count_en && valid_i && ready_i;

   always_comb
   begin
      // Clear first so the clearing beat lands on zero
      sof_nxt  = ctrl.clear ? '0 : sof_q;
      eol_nxt  = ctrl.clear ? '0 : eol_q;
      beat_nxt = ctrl.clear ? '0 : beat_q;
      if (hit)
      begin
         // Hold at all ones
         if (tuser_i && !(&sof_nxt))
         begin
            sof_nxt = sof_nxt + 1'b1;
         end
         if (tlast_i && !(&eol_nxt))
         begin
            eol_nxt = eol_nxt + 1'b1;
         end
         if (!(&beat_nxt))
         begin
            beat_nxt = beat_nxt + 1'b1;
         end
      end
   end

   // Live counts and snapshot word
   always_ff @(posedge reg_ctrl_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         sof_q   <= '0;
         eol_q   <= '0;
         beat_q  <= '0;
         stats_o <= '0;
      end
      else
      begin
         sof_q  <= sof_nxt;
         eol_q  <= eol_nxt;
         beat_q <= beat_nxt;
         if (ctrl.snapshot)
         begin
            stats_o <= {sof_q, eol_q, beat_q};
         end
      end
   end

endmodule

// ==== verilog/monitor_fsm.sv ====
// Windows align to an accepted camera tuser beat; clearing the enable aborts to idle
`timescale 1ns/1ns

module monitor_fsm import cam_mon_pkg::*;
(
   input  logic    reg_ctrl_clk,
   input  logic    arst_n_i,
   input  logic    enable_i,
   // Camera tuser beat accepted this cycle
   input  logic    sof_beat_i,
   input  logic    tick_i,
   output logic    start_o,
   mon_ctrl_if.fsm ctrl
);

   mon_state_t state_q;
   mon_state_t state_nxt;
   logic       arm_hit;

   // Frame start seen while armed
   assign arm_hit = (state_q == MON_ARM) && enable_i && sof_beat_i;

   // ********************
   // Next state
   // ********************
   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         MON_IDLE:    if (enable_i) state_nxt = MON_ARM;
         MON_ARM:     if (arm_hit) state_nxt = MON_MEASURE;
         MON_MEASURE: if (tick_i) state_nxt = MON_LATCH;
         MON_LATCH:   state_nxt = MON_ARM;
         default:     state_nxt = MON_IDLE;
      endcase
      // Disable wins from any state
      if (!enable_i)
      begin
         state_nxt = MON_IDLE;
      end
   end

   always_ff @(posedge reg_ctrl_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= MON_IDLE;
      end
      else
      begin
         state_q <= state_nxt;
      end
   end

   // ********************
   // Outputs
   // ********************
   // Arming beat clears, restarts the timer and is counted itself
   assign start_o       = arm_hit;
   assign ctrl.clear    = arm_hit;
   assign ctrl.count_en = arm_hit || (state_q == MON_MEASURE);
   assign ctrl.snapshot = (state_q == MON_LATCH);
   assign ctrl.state    = state_q;

endmodule

// ==== verilog/window_timer.sv ====
// Fixed window of WINDOW_CYCLES; a new start_i restarts a running window
`timescale 1ns/1ns

module window_timer import cam_mon_pkg::*;
(
   input  logic reg_ctrl_clk,
   input  logic arst_n_i,
   input  logic start_i,
   output logic tick_o
);

   win_cnt_t count_q;
   logic     running_q;
   logic     last_cycle;

   // Count 0 is the first cycle after start, so the last is WINDOW_CYCLES-1
   assign last_cycle = running_q && (count_q == WINDOW_CYCLES - 1'b1);
   assign tick_o     = last_cycle;

   always_ff @(posedge reg_ctrl_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         count_q   <= '0;
         running_q <= 1'b0;
      end
      else if (start_i)
      begin
         count_q   <= '0;
         running_q <= 1'b1;
      end
      else if (last_cycle)
      begin
         // Stop and wait for the next start
         running_q <= 1'b0;
      end
      else if (running_q)
      begin
         count_q <= count_q + 1'b1;
      end
   end

endmodule

// ==== verilog/pixel_repack.sv ====
// One-beat stage; input must hold valid and payload stable until accepted
`timescale 1ns/1ns

module pixel_repack import cam_mon_pkg::*;
(
   input  logic    reg_ctrl_clk,
   input  logic    arst_n_i,
   // Camera side
   input  pix565_t cam_tdata_i,
   input  logic    cam_tvalid_i,
   input  logic    cam_tuser_i,
   input  logic    cam_tlast_i,
   output logic    cam_tready_o,
   // Video side
   output pix888_t vid_tdata_o,
   output logic    vid_tvalid_o,
   output logic    vid_tuser_o,
   output logic    vid_tlast_o,
   input  logic    vid_tready_i
);

   logic load;

   // Accept when the stage is empty or drains this cycle
   assign cam_tready_o = !vid_tvalid_o || vid_tready_i;
   assign load         = cam_tvalid_i && cam_tready_o;

   // Stage occupancy
   always_ff @(posedge reg_ctrl_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         vid_tvalid_o <= 1'b0;
      end
      else if (load)
      begin
         vid_tvalid_o <= 1'b1;
      end
      else if (vid_tready_i)
      begin
         vid_tvalid_o <= 1'b0;
      end
   end

   // Payload, held under back-pressure
   always_ff @(posedge reg_ctrl_clk)
   begin
      if (load)
      begin
         // Bits 4..0 high byte, 15..11 middle, 10..5 low; zero fill below
         vid_tdata_o <= {cam_tdata_i[4:0],   3'd0,
                         cam_tdata_i[15:11], 3'd0,
                         cam_tdata_i[10:5],  2'd0};
         vid_tuser_o <= cam_tuser_i;
         vid_tlast_o <= cam_tlast_i;
      end
   end

endmodule

// ==== verilog/reg_bank.sv ====
// Word-indexed registers, one-cycle read latency; writes to read-only or unknown indices are ignored
`timescale 1ns/1ns

module reg_bank import cam_mon_pkg::*;
(
   input  logic             reg_ctrl_clk,
   input  logic             arst_n_i,
   // Register access port
   input  logic             reg_en_i,
   input  reg_be_t          reg_we_i,
   input  reg_addr_t        reg_addr_i,
   input  reg_data_t        reg_wdata_i,
   output reg_data_t        reg_rdata_o,
   // Snapshot words from the two monitors
   input  reg_data_t        in_stats_i,
   input  reg_data_t        out_stats_i,
   // Control outputs
   output logic             mon_enable_o,
   output logic [LED_W-1:0] led_o,
   mon_ctrl_if.regs         ctrl
);

   // ********************
   // Declarations
   // ********************
   reg_data_t led_ctrl_q;
   reg_data_t mon_ctrl_q;
   win_done_t win_done_q;
   logic      wr_en;
   logic      rd_en;
   reg_data_t status_word;

   // Merge write data into the old value lane by lane
   function automatic reg_data_t apply_be(reg_data_t old_val, reg_data_t new_val, reg_be_t be);
      reg_data_t res;
      res = old_val;
      for (int i = 0; i < $bits(reg_be_t); i++)
      begin
         if (be[i])
         begin
            res[i*8 +: 8] = new_val[i*8 +: 8];
         end
      end
      return res;
   endfunction

   // Any nonzero byte enable makes a write
   assign wr_en = reg_en_i && (reg_we_i != '0);
   assign rd_en = reg_en_i && (reg_we_i == '0);

   // Window count above, sequencer state in the low bits
   assign status_word = {16'h0000, win_done_q, 6'b000000, ctrl.state};

   // ********************
   // Writable registers
   // ********************
   always_ff @(posedge reg_ctrl_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         led_ctrl_q <= '0;
         mon_ctrl_q <= '0;
      end
      else if (wr_en)
      begin
         if (reg_addr_i == REG_LED_CTRL)
         begin
            led_ctrl_q <= apply_be(led_ctrl_q, reg_wdata_i, reg_we_i);
         end
         if (reg_addr_i == REG_MON_CTRL)
         begin
            mon_ctrl_q <= apply_be(mon_ctrl_q, reg_wdata_i, reg_we_i);
         end
      end
   end

   // Completed windows, one per snapshot, wraps at 8 bits
   always_ff @(posedge reg_ctrl_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         win_done_q <= '0;
      end
      else if (ctrl.snapshot)
      begin
         win_done_q <= win_done_q + 1'b1;
      end
   end

   // ********************
   // Read path
   // ********************
   always_ff @(posedge reg_ctrl_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         reg_rdata_o <= '0;
      end
      else if (rd_en)
      begin
         case (reg_addr_i)
            REG_FW_VER:    reg_rdata_o <= FW_VERSION;
            REG_LED_CTRL:  reg_rdata_o <= led_ctrl_q;
            REG_MON_CTRL:  reg_rdata_o <= mon_ctrl_q;
            REG_IN_STATS:  reg_rdata_o <= in_stats_i;
            REG_OUT_STATS: reg_rdata_o <= out_stats_i;
            REG_STATUS:    reg_rdata_o <= status_word;
            // Holes in the map
            default:       reg_rdata_o <= '0;
         endcase
      end
   end

   // LEDs track the register directly
   assign led_o        = led_ctrl_q[LED_W-1:0];
   assign mon_enable_o = mon_ctrl_q[MON_EN_BIT];

endmodule

// ==== verilog/mon_ctrl_if.sv ====
// Driven only by monitor_fsm; clear and snapshot are single-cycle pulses in reg_ctrl_clk
`timescale 1ns/1ns

interface mon_ctrl_if import cam_mon_pkg::*;
();

   // Zero the live counters
   logic       clear;
   // Counting window open
   logic       count_en;
   // Copy live counts to the stats words
   logic       snapshot;
   // Current sequencer state
   mon_state_t state;

   // Sequencer side
   modport fsm
   (
      output clear,
      output count_en,
      output snapshot,
      output state
   );

   // Beat counter side
   modport counter
   (
      input  clear,
      input  count_en,
      input  snapshot
   );

   // Register bank side
   modport regs
   (
      input  state,
      input  snapshot
   );

endinterface

// ==== verilog/cam_mon_pkg.sv ====
// Single clock domain only; all widths, register indices and the window length are fixed here

package cam_mon_pkg;

   // ********************
   // Stream beat types
   // ********************
   // RGB565 camera beat
   typedef logic [15:0] pix565_t;
   // Repacked video beat, three bytes
   typedef logic [23:0] pix888_t;

   // ********************
   // Register port types
   // ********************
   typedef logic [8:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;
   // One enable per byte lane
   typedef logic [3:0]  reg_be_t;

   // ********************
   // Counter types
   // ********************
   // Frame starts, stats bits 31..24
   typedef logic [7:0]  sof_cnt_t;
   // Line ends, stats bits 23..12
   typedef logic [11:0] eol_cnt_t;
   // Accepted beats, stats bits 11..0
   typedef logic [11:0] beat_cnt_t;
   // Window timer
   typedef logic [15:0] win_cnt_t;
   // Completed windows, status bits 15..8
   typedef logic [7:0]  win_done_t;

   // Sequencer states, also reported in status bits 1..0
   typedef enum logic [1:0]
   {
      MON_IDLE    = 2'd0,
      MON_ARM     = 2'd1,
      MON_MEASURE = 2'd2,
      MON_LATCH   = 2'd3
   } mon_state_t;

   // ********************
   // Constants
   // ********************
   localparam reg_data_t FW_VERSION    = 32'h0001_0000;
   // Window length in reg_ctrl_clk cycles
   localparam win_cnt_t  WINDOW_CYCLES = 16'd2000;
   // Width of the LED field in LED_CTRL
   localparam int        LED_W         = 4;
   // Monitor enable bit in MON_CTRL
   localparam int        MON_EN_BIT    = 0;

   // Register word indices
   localparam reg_addr_t REG_FW_VER    = 9'd0;
   localparam reg_addr_t REG_LED_CTRL  = 9'd1;
   localparam reg_addr_t REG_MON_CTRL  = 9'd2;
   localparam reg_addr_t REG_IN_STATS  = 9'd3;
   localparam reg_addr_t REG_OUT_STATS = 9'd4;
   localparam reg_addr_t REG_STATUS    = 9'd5;

endpackage
